//--- mem_bus_pkg.sv
package mem_bus_pkg;

    localparam int addr_width   = 32;
    localparam int data_width   = 64;
    localparam int strb_width   = data_width / 8;
    localparam int sram_words   = 256;
    localparam int offset_width = $clog2(strb_width);      // byte offset in a doubleword
    localparam int index_width  = $clog2(sram_words);
    localparam int sram_bytes   = sram_words * strb_width; // first byte out of range

    typedef enum logic [1:0] {
        size_b = 2'd0,  // 1 byte
        size_h = 2'd1,  // 2 bytes
        size_w = 2'd2,  // 4 bytes
        size_d = 2'd3   // full doubleword
    } size_t;

    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } resp_t;

    // unprivileged, secure, data access
    localparam logic [2:0] prot_data = 3'b000;

    // byte lanes touched by an access of the given size at the given offset
    function automatic logic [strb_width-1:0] size_to_strb(
        input size_t                   size,
        input logic [offset_width-1:0] offset
    );
        logic [strb_width-1:0] lanes;
        case (size)
            size_b:  lanes = strb_width'(1);
            size_h:  lanes = strb_width'(3);
            size_w:  lanes = strb_width'(15);
            default: lanes = '1;
        endcase
        return lanes << offset;  // accesses never cross a doubleword
    endfunction

endpackage

//--- mem_req_if.sv
interface mem_req_if;

    logic                               valid;  // held until done
    logic                               write;
    logic [mem_bus_pkg::addr_width-1:0] addr;
    mem_bus_pkg::size_t                 size;
    logic [mem_bus_pkg::data_width-1:0] wdata;  // right aligned
    logic                               done;   // one cycle pulse
    logic [mem_bus_pkg::data_width-1:0] rdata;  // valid with done only
    mem_bus_pkg::resp_t                 resp;

    modport requester (
        output valid,
        output write,
        output addr,
        output size,
        output wdata,
        input  done,
        input  rdata,
        input  resp
    );

    modport server (
        input  valid,
        input  write,
        input  addr,
        input  size,
        input  wdata,
        output done,
        output rdata,
        output resp
    );

endinterface

//--- axi_lite_if.sv
interface axi_lite_if;

    logic                               awvalid;
    logic                               awready;
    logic [mem_bus_pkg::addr_width-1:0] awaddr;
    logic [2:0]                         awprot;

    logic                               wvalid;
    logic                               wready;
    logic [mem_bus_pkg::data_width-1:0] wdata;
    logic [mem_bus_pkg::strb_width-1:0] wstrb;

    logic                               bvalid;
    logic                               bready;
    mem_bus_pkg::resp_t                 bresp;

    logic                               arvalid;
    logic                               arready;
    logic [mem_bus_pkg::addr_width-1:0] araddr;
    logic [2:0]                         arprot;

    logic                               rvalid;
    logic                               rready;
    logic [mem_bus_pkg::data_width-1:0] rdata;
    mem_bus_pkg::resp_t                 rresp;

    modport master (
        output awvalid, awaddr, awprot, wvalid, wdata, wstrb, bready,
        output arvalid, araddr, arprot, rready,
        input  awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
    );

    modport slave (
        input  awvalid, awaddr, awprot, wvalid, wdata, wstrb, bready,
        input  arvalid, araddr, arprot, rready,
        output awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
    );

endinterface

//--- port_arbiter.sv
module port_arbiter (
    input  logic                               clock,
    input  logic                               reset,

    input  logic                               fetch_valid_i,
    input  logic [mem_bus_pkg::addr_width-1:0] fetch_addr_i,
    output logic                               fetch_done_o,
    output logic [mem_bus_pkg::data_width-1:0] fetch_rdata_o,
    output mem_bus_pkg::resp_t                 fetch_resp_o,

    input  logic                               ls_valid_i,
    input  logic                               ls_write_i,
    input  logic [mem_bus_pkg::addr_width-1:0] ls_addr_i,
    input  mem_bus_pkg::size_t                 ls_size_i,
    input  logic [mem_bus_pkg::data_width-1:0] ls_wdata_i,
    output logic                               ls_done_o,
    output logic [mem_bus_pkg::data_width-1:0] ls_rdata_o,
    output mem_bus_pkg::resp_t                 ls_resp_o,

    mem_req_if.requester                       granted
);

    logic locked;       // transaction in flight
    logic owner_ls;     // port holding the grant, 1 for load/store
    logic last_ls;      // port served last
    logic sel_ls;
    logic grant_valid;

    always_comb begin
        if (locked) begin
            sel_ls = owner_ls;
        end else if (fetch_valid_i && ls_valid_i) begin
            sel_ls = !last_ls;  // tie goes to the other port
        end else begin
            sel_ls = ls_valid_i;
        end
    end

    assign grant_valid = sel_ls ? ls_valid_i : fetch_valid_i;

    always_comb begin
        granted.valid = grant_valid;
        if (sel_ls) begin
            granted.write = ls_write_i;
            granted.addr  = ls_addr_i;
            granted.size  = ls_size_i;
            granted.wdata = ls_wdata_i;
        end else begin
            granted.write = 1'b0;                   // fetch only reads
            granted.addr  = fetch_addr_i;
            granted.size  = mem_bus_pkg::size_d;    // whole doubleword
            granted.wdata = '0;
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            locked   <= 1'b0;
            owner_ls <= 1'b0;
            last_ls  <= 1'b1;   // fetch wins the first tie
        end else if (granted.done) begin
            locked  <= 1'b0;
            last_ls <= owner_ls;
        end else if (!locked && grant_valid) begin
            locked   <= 1'b1;
            owner_ls <= sel_ls;
        end
    end

    // completion goes back to the owning port
    assign fetch_done_o  = granted.done && !sel_ls;
    assign ls_done_o     = granted.done && sel_ls;
    assign fetch_rdata_o = granted.rdata;
    assign ls_rdata_o    = granted.rdata;
    assign fetch_resp_o  = granted.resp;
    assign ls_resp_o     = granted.resp;

endmodule

//--- axi_rw.sv
module axi_rw (
    input  logic       clock,
    input  logic       reset,
    mem_req_if.server  req,
    axi_lite_if.master axi
);

    typedef enum logic [2:0] {
        st_idle,
        st_rd_addr,
        st_rd_data,
        st_wr_addr_data,
        st_wr_resp,
        st_done
    } state_t;

    state_t                             state_q;
    state_t                             state_d;
    logic                               aw_done_q;  // AW finished in write state
    logic                               w_done_q;   // W finished in write state
    logic [mem_bus_pkg::addr_width-1:0] addr_q;
    logic [mem_bus_pkg::data_width-1:0] wdata_q;    // already on its byte lanes
    logic [mem_bus_pkg::strb_width-1:0] strb_q;
    logic [mem_bus_pkg::data_width-1:0] rdata_q;
    mem_bus_pkg::resp_t                 resp_q;
    logic                               aw_hs;
    logic                               w_hs;
    logic                               req_start;

    assign aw_hs     = axi.awvalid && axi.awready;
    assign w_hs      = axi.wvalid && axi.wready;
    assign req_start = (state_q == st_idle) && req.valid;

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (req.valid) begin
                    if (req.write) begin
                        state_d = st_wr_addr_data;
                    end else begin
                        state_d = st_rd_addr;
                    end
                end
            end
            st_rd_addr: begin
                if (axi.arready) begin
                    state_d = st_rd_data;
                end
            end
            st_rd_data: begin
                if (axi.rvalid) begin
                    state_d = st_done;
                end
            end
            st_wr_addr_data: begin
                // AW and W may finish in either order
                if ((aw_done_q || aw_hs) && (w_done_q || w_hs)) begin
                    state_d = st_wr_resp;
                end
            end
            st_wr_resp: begin
                if (axi.bvalid) begin
                    state_d = st_done;
                end
            end
            default: begin
                state_d = st_idle;  // done lasts one cycle
            end
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state_q   <= st_idle;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == st_idle) begin
                aw_done_q <= 1'b0;
                w_done_q  <= 1'b0;
            end else begin
                if (aw_hs) begin
                    aw_done_q <= 1'b1;
                end
                if (w_hs) begin
                    w_done_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (req_start) begin
            addr_q  <= req.addr;
            wdata_q <= req.wdata << {req.addr[mem_bus_pkg::offset_width-1:0], 3'b000};
            strb_q  <= mem_bus_pkg::size_to_strb(req.size,
                                                 req.addr[mem_bus_pkg::offset_width-1:0]);
        end
        if ((state_q == st_rd_data) && axi.rvalid) begin
            rdata_q <= axi.rdata;   // whole doubleword, requester picks bytes
            resp_q  <= axi.rresp;
        end
        if ((state_q == st_wr_resp) && axi.bvalid) begin
            rdata_q <= '0;
            resp_q  <= axi.bresp;
        end
    end

    assign axi.awvalid = (state_q == st_wr_addr_data) && !aw_done_q;
    assign axi.awaddr  = addr_q;
    assign axi.awprot  = mem_bus_pkg::prot_data;
    assign axi.wvalid  = (state_q == st_wr_addr_data) && !w_done_q;
    assign axi.wdata   = wdata_q;
    assign axi.wstrb   = strb_q;
    assign axi.bready  = (state_q == st_wr_resp);

    assign axi.arvalid = (state_q == st_rd_addr);
    assign axi.araddr  = addr_q;
    assign axi.arprot  = mem_bus_pkg::prot_data;
    assign axi.rready  = (state_q == st_rd_data);

    assign req.done  = (state_q == st_done);
    assign req.rdata = rdata_q;
    assign req.resp  = resp_q;

endmodule

//--- axi_lite_sram.sv
module axi_lite_sram (
    input  logic      clock,
    input  logic      reset,
    axi_lite_if.slave axi
);

    logic [mem_bus_pkg::data_width-1:0]  mem [mem_bus_pkg::sram_words];

    logic                                aw_held_q;
    logic                                w_held_q;
    logic [mem_bus_pkg::addr_width-1:0]  aw_addr_q;
    logic [mem_bus_pkg::data_width-1:0]  w_data_q;
    logic [mem_bus_pkg::strb_width-1:0]  w_strb_q;
    logic                                bvalid_q;
    logic                                rvalid_q;
    mem_bus_pkg::resp_t                  bresp_q;
    mem_bus_pkg::resp_t                  rresp_q;
    logic [mem_bus_pkg::data_width-1:0]  rdata_q;
    logic [1:0]                          throttle_q;    // free-running mod 3

    logic                                resp_wait;
    logic                                aw_hs;
    logic                                w_hs;
    logic                                ar_hs;
    logic                                wr_commit;
    logic [mem_bus_pkg::addr_width-1:0]  wr_addr;
    logic [mem_bus_pkg::data_width-1:0]  wr_data;
    logic [mem_bus_pkg::strb_width-1:0]  wr_strb;
    logic                                wr_in_range;
    logic                                rd_in_range;
    logic [mem_bus_pkg::index_width-1:0] wr_idx;
    logic [mem_bus_pkg::index_width-1:0] rd_idx;

    // back-pressure while any response is pending
    assign resp_wait   = bvalid_q || rvalid_q;
    assign axi.awready = !aw_held_q && !resp_wait;
    assign axi.wready  = !w_held_q && !resp_wait;
    assign axi.arready = !resp_wait && (throttle_q != 2'd2);   // wait state every third cycle

    assign aw_hs = axi.awvalid && axi.awready;
    assign w_hs  = axi.wvalid && axi.wready;
    assign ar_hs = axi.arvalid && axi.arready;

    // write goes in once both halves are here
    assign wr_commit = (aw_held_q || aw_hs) && (w_held_q || w_hs);
    assign wr_addr   = aw_held_q ? aw_addr_q : axi.awaddr;
    assign wr_data   = w_held_q ? w_data_q : axi.wdata;
    assign wr_strb   = w_held_q ? w_strb_q : axi.wstrb;

    assign wr_in_range = wr_addr < mem_bus_pkg::sram_bytes;
    assign rd_in_range = axi.araddr < mem_bus_pkg::sram_bytes;
    assign wr_idx      = wr_addr[mem_bus_pkg::offset_width +: mem_bus_pkg::index_width];
    assign rd_idx      = axi.araddr[mem_bus_pkg::offset_width +: mem_bus_pkg::index_width];

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            aw_held_q  <= 1'b0;
            w_held_q   <= 1'b0;
            bvalid_q   <= 1'b0;
            rvalid_q   <= 1'b0;
            throttle_q <= 2'd0;
        end else begin
            throttle_q <= (throttle_q == 2'd2) ? 2'd0 : throttle_q + 2'd1;
            if (wr_commit) begin
                aw_held_q <= 1'b0;
                w_held_q  <= 1'b0;
                bvalid_q  <= 1'b1;
            end else begin
                if (aw_hs) begin
                    aw_held_q <= 1'b1;
                end
                if (w_hs) begin
                    w_held_q <= 1'b1;
                end
                if (axi.bready) begin
                    bvalid_q <= 1'b0;
                end
            end
            if (ar_hs) begin
                rvalid_q <= 1'b1;
            end else if (axi.rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (aw_hs) begin
            aw_addr_q <= axi.awaddr;
        end
        if (w_hs) begin
            w_data_q <= axi.wdata;
            w_strb_q <= axi.wstrb;
        end
        if (wr_commit) begin
            if (wr_in_range) begin
                bresp_q <= mem_bus_pkg::resp_okay;
                for (int i = 0; i < mem_bus_pkg::strb_width; i++) begin
                    if (wr_strb[i]) begin
                        mem[wr_idx][8*i +: 8] <= wr_data[8*i +: 8];
                    end
                end
            end else begin
                bresp_q <= mem_bus_pkg::resp_slverr;    // nothing written
            end
        end
        if (ar_hs) begin
            if (rd_in_range) begin
                rdata_q <= mem[rd_idx];
                rresp_q <= mem_bus_pkg::resp_okay;
            end else begin
                rdata_q <= '0;
                rresp_q <= mem_bus_pkg::resp_slverr;
            end
        end
    end

    assign axi.bvalid = bvalid_q;
    assign axi.bresp  = bresp_q;
    assign axi.rvalid = rvalid_q;
    assign axi.rdata  = rdata_q;
    assign axi.rresp  = rresp_q;

endmodule

//--- mem_subsys_top.sv
module mem_subsys_top (
    input  logic                               clock,
    input  logic                               reset,

    input  logic                               fetch_valid_i,
    input  logic [mem_bus_pkg::addr_width-1:0] fetch_addr_i,
    output logic                               fetch_done_o,
    output logic [mem_bus_pkg::data_width-1:0] fetch_rdata_o,
    output mem_bus_pkg::resp_t                 fetch_resp_o,

    input  logic                               ls_valid_i,
    input  logic                               ls_write_i,
    input  logic [mem_bus_pkg::addr_width-1:0] ls_addr_i,
    input  mem_bus_pkg::size_t                 ls_size_i,
    input  logic [mem_bus_pkg::data_width-1:0] ls_wdata_i,
    output logic                               ls_done_o,
    output logic [mem_bus_pkg::data_width-1:0] ls_rdata_o,
    output mem_bus_pkg::resp_t                 ls_resp_o
);

    mem_req_if  granted ();     // arbiter to bridge
    axi_lite_if axi_bus ();     // bridge to SRAM

    port_arbiter u_arbiter (
        .clock         (clock),
        .reset         (reset),
        .fetch_valid_i (fetch_valid_i),
        .fetch_addr_i  (fetch_addr_i),
        .fetch_done_o  (fetch_done_o),
        .fetch_rdata_o (fetch_rdata_o),
        .fetch_resp_o  (fetch_resp_o),
        .ls_valid_i    (ls_valid_i),
        .ls_write_i    (ls_write_i),
        .ls_addr_i     (ls_addr_i),
        .ls_size_i     (ls_size_i),
        .ls_wdata_i    (ls_wdata_i),
        .ls_done_o     (ls_done_o),
        .ls_rdata_o    (ls_rdata_o),
        .ls_resp_o     (ls_resp_o),
        .granted       (granted)
    );

    axi_rw u_axi_rw (
        .clock (clock),
        .reset (reset),
        .req   (granted),
        .axi   (axi_bus)
    );

    axi_lite_sram u_sram (
        .clock (clock),
        .reset (reset),
        .axi   (axi_bus)
    );

endmodule

//--- tb_mem_subsys.sv
module tb_mem_subsys;

    localparam int num_ls      = 200;
    localparam int num_fetch   = 150;
    localparam int cycle_limit = (mem_bus_pkg::sram_words + num_ls + num_fetch + 1) * 12 + 200;

    logic                               clock;
    logic                               reset;
    logic                               fetch_valid_i;
    logic [mem_bus_pkg::addr_width-1:0] fetch_addr_i;
    logic                               fetch_done_o;
    logic [mem_bus_pkg::data_width-1:0] fetch_rdata_o;
    mem_bus_pkg::resp_t                 fetch_resp_o;
    logic                               ls_valid_i;
    logic                               ls_write_i;
    logic [mem_bus_pkg::addr_width-1:0] ls_addr_i;
    mem_bus_pkg::size_t                 ls_size_i;
    logic [mem_bus_pkg::data_width-1:0] ls_wdata_i;
    logic                               ls_done_o;
    logic [mem_bus_pkg::data_width-1:0] ls_rdata_o;
    mem_bus_pkg::resp_t                 ls_resp_o;

    logic [mem_bus_pkg::data_width-1:0] model [mem_bus_pkg::sram_words];  // expected SRAM
    integer                             seed = 32'h49e0a2c9;
    int                                 errors = 0;
    int                                 protocol_errors = 0;
    int                                 checks = 0;
    int                                 ties = 0;
    int                                 cycles = 0;
    logic                               init_done = 1'b0;
    logic                               fetch_done_seen = 1'b0;    // sampled mid cycle
    logic                               ls_done_seen = 1'b0;
    logic                               exp_locked;
    logic                               exp_owner_ls;
    logic                               exp_last_ls;
    logic                               exp_first_tie = 1'b0;      // grant came from the first tie
    mem_bus_pkg::size_t                 next_size;
    logic                               next_write;
    logic [mem_bus_pkg::addr_width-1:0] next_addr;

    mem_subsys_top uut (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    initial begin
        while (cycles < cycle_limit) begin
            @(posedge clock);
            cycles++;
        end
        $display("timeout after %0d cycles, the requests did not all complete", cycles);
        $display("Simulation failed");
        $finish;
    end

    task automatic check_completion(input string port, input logic write, input logic [31:0] addr,
                                    input mem_bus_pkg::size_t size, input logic [63:0] wdata,
                                    input logic [63:0] rdata, input mem_bus_pkg::resp_t resp);
        logic                               in_range;
        logic [mem_bus_pkg::strb_width-1:0] strb;
        logic [mem_bus_pkg::data_width-1:0] exp_rdata;
        in_range  = addr < mem_bus_pkg::sram_bytes;
        exp_rdata = in_range ? model[addr[10:3]] : '0;
        strb      = mem_bus_pkg::size_to_strb(size, addr[2:0]);
        checks++;
        assert (resp == (in_range ? mem_bus_pkg::resp_okay : mem_bus_pkg::resp_slverr)) else begin
            errors++;
            $display("ERR %0t: %s response %0d at address %h", $time, port, resp, addr);
        end
        assert (write || rdata === exp_rdata) else begin
            errors++;
            $display("ERR %0t: %s read %h at address %h, expected %h",
                     $time, port, rdata, addr, exp_rdata);
        end
        if (write && in_range) begin
            for (int i = 0; i < mem_bus_pkg::strb_width; i++) begin
                if (strb[i]) begin
                    model[addr[10:3]][8*i +: 8] = wdata[8*(i - int'(addr[2:0])) +: 8];
                end
            end
        end
    endtask

    task automatic ls_access(input logic write, input logic [31:0] addr,
                             input mem_bus_pkg::size_t size, input logic [63:0] wdata);
        ls_valid_i = 1'b1;
        ls_write_i = write;
        ls_addr_i  = addr;
        ls_size_i  = size;
        ls_wdata_i = wdata;
        @(negedge clock);
        while (!ls_done_o) begin
            @(negedge clock);
        end
        check_completion("load/store", write, addr, size, wdata, ls_rdata_o, ls_resp_o);
        @(negedge clock);   // held through the done cycle
        ls_valid_i = 1'b0;
    endtask

    task automatic fetch_access(input logic [31:0] addr);
        fetch_valid_i = 1'b1;
        fetch_addr_i  = addr;
        @(negedge clock);
        while (!fetch_done_o) begin
            @(negedge clock);
        end
        check_completion("fetch", 1'b0, addr, mem_bus_pkg::size_d, '0, fetch_rdata_o, fetch_resp_o);
        @(negedge clock);
        fetch_valid_i = 1'b0;
    endtask

    function automatic logic [31:0] random_addr(input mem_bus_pkg::size_t size);
        logic [31:0] addr;
        addr = $unsigned($random(seed)) % mem_bus_pkg::sram_bytes;
        if ($unsigned($random(seed)) % 10 == 0) begin
            addr = addr | (32'h800 << ($unsigned($random(seed)) % 21));   // past the SRAM
        end
        return addr & ~((32'd1 << size) - 32'd1);   // aligned to its size
    endfunction

    always @(negedge clock) begin
        fetch_done_seen <= fetch_done_o;
        ls_done_seen    <= ls_done_o;
    end

    // round robin grant model, locked until done
    always @(posedge clock) begin
        if (!reset) begin
            exp_locked    = 1'b0;
            exp_last_ls   = 1'b1;
            exp_first_tie = 1'b0;
        end else if (exp_locked) begin
            if (fetch_done_seen || ls_done_seen) begin
                assert (fetch_done_seen != ls_done_seen && ls_done_seen == exp_owner_ls
                        && (ls_done_seen ? ls_valid_i : fetch_valid_i)) else begin
                    protocol_errors++;
                    $display("at %0t a done pulse reached a port that did not own the request",
                             $time);
                end
                assert (!exp_first_tie || fetch_done_seen) else begin
                    protocol_errors++;
                    $display("at %0t the first tie after reset did not go to fetch", $time);
                end
                exp_last_ls = exp_owner_ls;
                exp_locked  = 1'b0;
            end
        end else begin
            assert (!fetch_done_seen && !ls_done_seen) else begin
                protocol_errors++;
                $display("at %0t a done pulse arrived with no request in flight", $time);
            end
            if (fetch_valid_i && ls_valid_i) begin
                exp_owner_ls  = !exp_last_ls;
                exp_first_tie = (ties == 0);
                ties++;
            end else begin
                exp_owner_ls  = ls_valid_i;
                exp_first_tie = 1'b0;
            end
            exp_locked = fetch_valid_i || ls_valid_i;
        end
    end

    initial begin
        reset         = 1'b0;
        fetch_valid_i = 1'b0;
        fetch_addr_i  = '0;
        ls_valid_i    = 1'b0;
        ls_write_i    = 1'b0;
        ls_addr_i     = '0;
        ls_size_i     = mem_bus_pkg::size_b;
        ls_wdata_i    = '0;
        repeat (2) @(negedge clock);
        reset = 1'b1;
        @(negedge clock);
        assert (!fetch_done_o && !ls_done_o) else begin
            protocol_errors++;
            $display("at %0t a done pulse came out before any request", $time);
        end
        fork
            begin
                // fill the whole SRAM first
                for (int i = 0; i < mem_bus_pkg::sram_words; i++) begin
                    ls_access(1'b1, 32'(i) << 3, mem_bus_pkg::size_d,
                              {32'(i) << 3, ~(32'(i) << 3)} ^ 64'h5a5a_0000_0000_a5a5);
                end
                init_done = 1'b1;
                repeat (num_ls) begin
                    next_size  = mem_bus_pkg::size_t'(2'($random(seed)));
                    next_write = ($random(seed) % 2) != 0;
                    next_addr  = random_addr(next_size);
                    ls_access(next_write, next_addr, next_size, {$random(seed), $random(seed)});
                    repeat ($unsigned($random(seed)) % 3) @(negedge clock);
                end
            end
            begin
                fetch_access(mem_bus_pkg::sram_bytes);  // ties with the first fill write
                wait (init_done);
                @(negedge clock);
                repeat (num_fetch) begin
                    fetch_access(random_addr(mem_bus_pkg::size_d));
                    repeat ($unsigned($random(seed)) % 3) @(negedge clock);
                end
            end
        join
        $display("checks %0d, ties %0d, value errors %0d, protocol errors %0d",
                 checks, ties, errors, protocol_errors);
        if (errors + protocol_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
mem_bus_pkg.sv
mem_req_if.sv
axi_lite_if.sv
port_arbiter.sv
axi_rw.sv
axi_lite_sram.sv
mem_subsys_top.sv
tb_mem_subsys.sv

//--- run.sh
#!/bin/sh
# build and run with Verilator, pass only if the pass message shows up
verilator --binary --timing --assert --top-module tb_mem_subsys -f filelist.f -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "Simulation passed" \
    || { echo "simulation run did not pass"; exit 1; }
